/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
   input wire logic i_clock,
   input wire logic i_soft_reset,
   input wire logic i_enable,
   input wire logic [mips_mem_pkg::WORD_ADDR_WIDTH-1:0] i_word_addr,
   input wire logic [mips_mem_pkg::NUM_LANES-1:0] i_lane_we,
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_data,
   output logic [mips_mem_pkg::DATA_WIDTH-1:0] o_data
);

   localparam int LW = mips_mem_pkg::LANE_WIDTH;

   logic [mips_mem_pkg::DATA_WIDTH-1:0] mem [mips_mem_pkg::RAM_DEPTH];

   ////////////////////////////////////////
   // Byte-lane write port.
   ////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (i_enable) begin
         for (int lane = 0; lane < mips_mem_pkg::NUM_LANES; lane++) begin
            if (i_lane_we[lane]) begin
               mem[i_word_addr][lane*LW +: LW] <= i_data[lane*LW +: LW];
            end
         end
      end
   end

   ////////////////////////////////////////
   // Registered read port.
   ////////////////////////////////////////

   // A store returns the old word on the same address.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_data <= '0;
      end else if (i_enable) begin
         o_data <= mem[i_word_addr];
      end
   end

endmodule

`default_nettype wire

/* dirty_bit_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module dirty_bit_tracker (
   input wire logic i_clock,
   input wire logic i_soft_reset,
   input wire logic i_enable,
   input wire logic [mips_mem_pkg::WORD_ADDR_WIDTH-1:0] i_word_addr,
   input wire logic [mips_mem_pkg::NUM_LANES-1:0] i_lane_we,
   output logic o_bit_sucio
);

   // One written flag per memory word.
   logic [mips_mem_pkg::RAM_DEPTH-1:0] dirty;

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         dirty <= '0;
      end else if (i_enable && (i_lane_we != '0)) begin
         dirty[i_word_addr] <= 1'b1;
      end
   end

   // Same timing as the RAM read, so the flag is the one from before this write.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_bit_sucio <= 1'b0;
      end else if (i_enable) begin
         o_bit_sucio <= dirty[i_word_addr];
      end
   end

endmodule

`default_nettype wire

/* files.f */
mips_mem_pkg.sv
mips_ctrl_pkg.sv
mem_access_ctrl.sv
data_ram.sv
dirty_bit_tracker.sv
load_align.sv
mem_wb_register.sv
mem_stage_top.sv
mem_stage_props.sv
tb_mem_stage.sv

/* load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align (
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_word,
   input wire logic [mips_ctrl_pkg::SEL_WIDTH-1:0] i_select_bytes,
   input wire logic [mips_mem_pkg::LSB_WIDTH-1:0] i_addr_lsb,
   output logic [mips_mem_pkg::DATA_WIDTH-1:0] o_data
);

   localparam int DW = mips_mem_pkg::DATA_WIDTH;
   localparam int LW = mips_mem_pkg::LANE_WIDTH;
   localparam int HW = mips_mem_pkg::HALF_WIDTH;

   mips_mem_pkg::mem_word_u word_view;
   logic [LW-1:0] byte_pick;
   logic [HW-1:0] half_pick;
   logic byte_fill;
   logic half_fill;
   logic is_unsigned;

   assign word_view = i_word;

   ////////////////////////////////////////
   // Pick the addressed piece.
   ////////////////////////////////////////

   assign byte_pick = word_view.bytes[i_addr_lsb];
   // Bit 0 is ignored for halfwords.
   assign half_pick = word_view.halves[i_addr_lsb[1]];

   ////////////////////////////////////////
   // Sign or zero extension.
   ////////////////////////////////////////

   assign is_unsigned = i_select_bytes[mips_ctrl_pkg::SEL_UNSIGNED_BIT];
   assign byte_fill = ~is_unsigned & byte_pick[LW-1];
   assign half_fill = ~is_unsigned & half_pick[HW-1];

   always_comb begin
      case (i_select_bytes[mips_ctrl_pkg::SIZE_WIDTH-1:0])
         mips_ctrl_pkg::SIZE_BYTE: o_data = {{(DW-LW){byte_fill}}, byte_pick};
         mips_ctrl_pkg::SIZE_HALF: o_data = {{(DW-HW){half_fill}}, half_pick};
         // Word loads and the unused size code return the whole word.
         default: o_data = word_view;
      endcase
   end

endmodule

`default_nettype wire

/* mem_access_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
   input wire logic i_control_address_mem,
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_address_alu,
   input wire logic [mips_mem_pkg::ADDR_WIDTH-1:0] i_address_debug,
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_data_write_mem,
   input wire logic i_mem_write,
   input wire logic [mips_ctrl_pkg::SEL_WIDTH-1:0] i_select_bytes,
   input wire logic i_enable_mem,
   input wire logic i_enable_pipeline,
   output logic [mips_mem_pkg::ADDR_WIDTH-1:0] o_address,
   output logic [mips_mem_pkg::NUM_LANES-1:0] o_lane_we,
   output logic [mips_mem_pkg::DATA_WIDTH-1:0] o_data_lanes
);

   logic [mips_ctrl_pkg::SIZE_WIDTH-1:0] size;
   logic [mips_mem_pkg::LSB_WIDTH-1:0] lsb;
   logic [mips_mem_pkg::NUM_LANES-1:0] lane_mask;
   logic write_ok;

   // Debug selection takes the debug address.
   assign o_address = i_control_address_mem ? i_address_debug :
                      i_address_alu[mips_mem_pkg::ADDR_WIDTH-1:0];

   assign size = i_select_bytes[mips_ctrl_pkg::SIZE_WIDTH-1:0];
   assign lsb = o_address[mips_mem_pkg::LSB_WIDTH-1:0];

   // Lanes touched by an aligned store. A misaligned store touches none.
   always_comb begin
      lane_mask = '0;
      case (size)
         mips_ctrl_pkg::SIZE_BYTE: lane_mask = 4'b0001 << lsb;
         mips_ctrl_pkg::SIZE_HALF: begin
            if (!lsb[0]) begin
               lane_mask = lsb[1] ? 4'b1100 : 4'b0011;
            end
         end
         mips_ctrl_pkg::SIZE_WORD: begin
            if (lsb == '0) begin
               lane_mask = 4'b1111;
            end
         end
         default: lane_mask = '0;
      endcase
   end

   // The debug port only reads.
   assign write_ok = i_mem_write & ~i_control_address_mem & i_enable_mem & i_enable_pipeline;
   assign o_lane_we = write_ok ? lane_mask : '0;

   // Replicate narrow stores so every lane sees its own copy.
   always_comb begin
      case (size)
         mips_ctrl_pkg::SIZE_BYTE:
            o_data_lanes = {mips_mem_pkg::NUM_LANES{i_data_write_mem[7:0]}};
         mips_ctrl_pkg::SIZE_HALF:
            o_data_lanes = {2{i_data_write_mem[15:0]}};
         default: o_data_lanes = i_data_write_mem;
      endcase
   end

endmodule

`default_nettype wire

/* mem_stage_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_props (
   input wire logic i_clock,
   input wire logic i_soft_reset,
   input wire logic i_enable_pipeline,
   input wire logic i_control_address_mem,
   input wire logic [mips_mem_pkg::NUM_LANES-1:0] i_lane_we,
   input wire logic i_reg_write,
   input wire logic i_mem_to_reg,
   input wire logic i_halt_detected,
   input wire logic [mips_mem_pkg::REG_ADDR_WIDTH-1:0] i_registro_destino,
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_data_alu,
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_data_mem,
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_dato_debug,
   input wire logic i_bit_sucio
);

   // Number of failed assertions.
   int unsigned fail_count = 0;

   // The debug port never writes.
   assert property (@(posedge i_clock) i_control_address_mem |-> (i_lane_we == '0))
      else begin
         $error("Lane enables active while the debug address is selected.");
         fail_count++;
      end

   assert property (@(posedge i_clock) !i_soft_reset |=>
      (!i_reg_write && !i_mem_to_reg && !i_halt_detected &&
       (i_registro_destino == '0) && (i_data_alu == '0)))
      else begin
         $error("MEM/WB outputs not cleared after reset.");
         fail_count++;
      end

   // A stalled stage keeps every output.
   assert property (@(posedge i_clock) (i_soft_reset && !i_enable_pipeline) |=>
      $stable({i_reg_write, i_mem_to_reg, i_halt_detected, i_registro_destino,
               i_data_alu, i_data_mem, i_dato_debug, i_bit_sucio}))
      else begin
         $error("Outputs changed while the pipeline was stalled.");
         fail_count++;
      end

endmodule

bind mem_stage_top mem_stage_props u_mem_stage_props (
   .i_clock (i_clock),
   .i_soft_reset (i_soft_reset),
   .i_enable_pipeline (i_enable_pipeline),
   .i_control_address_mem (i_control_address_mem),
   .i_lane_we (lane_we),
   .i_reg_write (o_reg_write),
   .i_mem_to_reg (o_mem_to_reg),
   .i_halt_detected (o_halt_detected),
   .i_registro_destino (o_registro_destino),
   .i_data_alu (o_data_alu),
   .i_data_mem (o_data_mem),
   .i_dato_debug (o_dato_mem_to_debug_unit),
   .i_bit_sucio (o_bit_sucio_to_debug_unit)
);

`default_nettype wire

/* mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
   input wire logic i_clock,
   input wire logic i_soft_reset,
   input wire logic i_enable_pipeline,
   input wire logic i_enable_mem,
   input wire logic i_control_address_mem,
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_address_alu,
   input wire logic [mips_mem_pkg::ADDR_WIDTH-1:0] i_address_debug,
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_data_write_mem,
   input wire logic i_mem_read,
   input wire logic i_mem_write,
   input wire logic [mips_ctrl_pkg::SEL_WIDTH-1:0] i_select_bytes,
   input wire logic i_reg_write,
   input wire logic i_mem_to_reg,
   input wire logic [mips_mem_pkg::REG_ADDR_WIDTH-1:0] i_registro_destino,
   input wire logic i_halt_detected,
   output logic o_reg_write,
   output logic o_mem_to_reg,
   output logic [mips_mem_pkg::REG_ADDR_WIDTH-1:0] o_registro_destino,
   output logic o_halt_detected,
   output logic [mips_mem_pkg::DATA_WIDTH-1:0] o_data_alu,
   output logic [mips_mem_pkg::DATA_WIDTH-1:0] o_data_mem,
   output logic [mips_mem_pkg::DATA_WIDTH-1:0] o_dato_mem_to_debug_unit,
   output logic o_bit_sucio_to_debug_unit
);

   localparam int AW = mips_mem_pkg::ADDR_WIDTH;
   localparam int LSBW = mips_mem_pkg::LSB_WIDTH;

   logic [AW-1:0] address_mem;
   logic [mips_mem_pkg::NUM_LANES-1:0] lane_we;
   logic [mips_mem_pkg::DATA_WIDTH-1:0] data_lanes;
   logic [mips_ctrl_pkg::SEL_WIDTH-1:0] select_bytes_wb;
   logic [LSBW-1:0] addr_lsb_wb;

   mem_access_ctrl u_mem_access_ctrl (
      .i_control_address_mem (i_control_address_mem),
      .i_address_alu (i_address_alu),
      .i_address_debug (i_address_debug),
      .i_data_write_mem (i_data_write_mem),
      .i_mem_write (i_mem_write),
      .i_select_bytes (i_select_bytes),
      .i_enable_mem (i_enable_mem),
      .i_enable_pipeline (i_enable_pipeline),
      .o_address (address_mem),
      .o_lane_we (lane_we),
      .o_data_lanes (data_lanes)
   );

   // The RAM port runs for loads, stores and debug reads.
   data_ram u_data_ram (
      .i_clock (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_enable (i_enable_mem & i_enable_pipeline &
                 (i_mem_read | i_mem_write | i_control_address_mem)),
      .i_word_addr (address_mem[AW-1:LSBW]),
      .i_lane_we (lane_we),
      .i_data (data_lanes),
      .o_data (o_dato_mem_to_debug_unit)
   );

   dirty_bit_tracker u_dirty_bit_tracker (
      .i_clock (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_enable (i_enable_mem & i_enable_pipeline &
                 (i_mem_read | i_mem_write | i_control_address_mem)),
      .i_word_addr (address_mem[AW-1:LSBW]),
      .i_lane_we (lane_we),
      .o_bit_sucio (o_bit_sucio_to_debug_unit)
   );

   mem_wb_register u_mem_wb_register (
      .i_clock (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_enable_pipeline (i_enable_pipeline),
      .i_reg_write (i_reg_write),
      .i_mem_to_reg (i_mem_to_reg),
      .i_registro_destino (i_registro_destino),
      .i_halt_detected (i_halt_detected),
      .i_address_alu (i_address_alu),
      .i_select_bytes (i_select_bytes),
      .i_addr_lsb (address_mem[LSBW-1:0]),
      .o_reg_write (o_reg_write),
      .o_mem_to_reg (o_mem_to_reg),
      .o_registro_destino (o_registro_destino),
      .o_halt_detected (o_halt_detected),
      .o_data_alu (o_data_alu),
      .o_select_bytes (select_bytes_wb),
      .o_addr_lsb (addr_lsb_wb)
   );

   // Aligns the registered read word with the registered load context.
   load_align u_load_align (
      .i_word (o_dato_mem_to_debug_unit),
      .i_select_bytes (select_bytes_wb),
      .i_addr_lsb (addr_lsb_wb),
      .o_data (o_data_mem)
   );

endmodule

`default_nettype wire

/* mem_wb_register.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_register (
   input wire logic i_clock,
   input wire logic i_soft_reset,
   input wire logic i_enable_pipeline,
   input wire logic i_reg_write,
   input wire logic i_mem_to_reg,
   input wire logic [mips_mem_pkg::REG_ADDR_WIDTH-1:0] i_registro_destino,
   input wire logic i_halt_detected,
   input wire logic [mips_mem_pkg::DATA_WIDTH-1:0] i_address_alu,
   input wire logic [mips_ctrl_pkg::SEL_WIDTH-1:0] i_select_bytes,
   input wire logic [mips_mem_pkg::LSB_WIDTH-1:0] i_addr_lsb,
   output logic o_reg_write,
   output logic o_mem_to_reg,
   output logic [mips_mem_pkg::REG_ADDR_WIDTH-1:0] o_registro_destino,
   output logic o_halt_detected,
   output logic [mips_mem_pkg::DATA_WIDTH-1:0] o_data_alu,
   output logic [mips_ctrl_pkg::SEL_WIDTH-1:0] o_select_bytes,
   output logic [mips_mem_pkg::LSB_WIDTH-1:0] o_addr_lsb
);

   // Write-back controls and ALU result.
   // Everything holds while the pipeline is stalled.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_reg_write <= 1'b0;
         o_mem_to_reg <= 1'b0;
         o_registro_destino <= '0;
         o_halt_detected <= 1'b0;
         o_data_alu <= '0;
      end else if (i_enable_pipeline) begin
         o_reg_write <= i_reg_write;
         o_mem_to_reg <= i_mem_to_reg;
         o_registro_destino <= i_registro_destino;
         o_halt_detected <= i_halt_detected;
         o_data_alu <= i_address_alu;
      end
   end

   // The aligner uses this load context next to the registered RAM word.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_select_bytes <= '0;
         o_addr_lsb <= '0;
      end else if (i_enable_pipeline) begin
         o_select_bytes <= i_select_bytes;
         o_addr_lsb <= i_addr_lsb;
      end
   end

endmodule

`default_nettype wire

/* mips_ctrl_pkg.sv */
`default_nettype none

package mips_ctrl_pkg;

   ////////////////////////////////////////
   // Load and store select.
   ////////////////////////////////////////

   // Upper bit marks an unsigned load, lower two bits give the size.
   localparam int SEL_WIDTH = 3;
   localparam int SIZE_WIDTH = 2;
   localparam int SEL_UNSIGNED_BIT = 2;

   // Full select codes.
   localparam logic [SEL_WIDTH-1:0] SEL_BYTE = 3'b000;
   localparam logic [SEL_WIDTH-1:0] SEL_HALF = 3'b001;
   localparam logic [SEL_WIDTH-1:0] SEL_WORD = 3'b011;
   localparam logic [SEL_WIDTH-1:0] SEL_BYTEU = 3'b100;
   localparam logic [SEL_WIDTH-1:0] SEL_HALFU = 3'b101;

   // Size field values.
   localparam logic [SIZE_WIDTH-1:0] SIZE_BYTE = 2'b00;
   localparam logic [SIZE_WIDTH-1:0] SIZE_HALF = 2'b01;
   localparam logic [SIZE_WIDTH-1:0] SIZE_WORD = 2'b11;

endpackage

`default_nettype wire

/* mips_mem_pkg.sv */
`default_nettype none

package mips_mem_pkg;

   ////////////////////////////////////////
   // Memory geometry.
   ////////////////////////////////////////

   // Register and memory word width.
   localparam int DATA_WIDTH = 32;

   // Byte lanes per word.
   localparam int NUM_LANES = 4;
   localparam int LANE_WIDTH = DATA_WIDTH / NUM_LANES;
   localparam int HALF_WIDTH = DATA_WIDTH / 2;

   // Words in data memory.
   localparam int RAM_DEPTH = 256;
   localparam int WORD_ADDR_WIDTH = $clog2(RAM_DEPTH);

   // The low bits pick the byte inside a word.
   localparam int LSB_WIDTH = $clog2(NUM_LANES);
   localparam int ADDR_WIDTH = WORD_ADDR_WIDTH + LSB_WIDTH;

   // Destination register index.
   localparam int REG_ADDR_WIDTH = 5;

   ////////////////////////////////////////
   // Two views of one data word.
   ////////////////////////////////////////

   // Lane 0 holds bits 7:0, so byte offset 0 is the low byte.
   typedef union packed {
      logic [NUM_LANES-1:0][LANE_WIDTH-1:0] bytes;
      logic [1:0][HALF_WIDTH-1:0] halves;
   } mem_word_u;

endpackage

`default_nettype wire

/* tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

   localparam int CLK_PERIOD = 4;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_TEST_WORDS = 8;
   localparam int DW = mips_mem_pkg::DATA_WIDTH;
   localparam int AW = mips_mem_pkg::ADDR_WIDTH;
   localparam int WW = mips_mem_pkg::WORD_ADDR_WIDTH;
   localparam int DEPTH = mips_mem_pkg::RAM_DEPTH;
   // Reset, two full scans, word tests, narrow tests, misaligned and stall.
   localparam int TEST_CYCLES = RESET_CYCLES + 2 * DEPTH + 2 * NUM_TEST_WORDS +
                                4 * 6 * 14 + 12 + 19;
   localparam int BUDGET = 2 * TEST_CYCLES;

   logic i_clock = 1'b0;
   logic i_soft_reset;
   logic i_enable_pipeline;
   logic i_enable_mem;
   logic i_control_address_mem;
   logic [DW-1:0] i_address_alu;
   logic [AW-1:0] i_address_debug;
   logic [DW-1:0] i_data_write_mem;
   logic i_mem_read;
   logic i_mem_write;
   logic [mips_ctrl_pkg::SEL_WIDTH-1:0] i_select_bytes;
   logic i_reg_write;
   logic i_mem_to_reg;
   logic [mips_mem_pkg::REG_ADDR_WIDTH-1:0] i_registro_destino;
   logic i_halt_detected;
   logic o_reg_write;
   logic o_mem_to_reg;
   logic [mips_mem_pkg::REG_ADDR_WIDTH-1:0] o_registro_destino;
   logic o_halt_detected;
   logic [DW-1:0] o_data_alu;
   logic [DW-1:0] o_data_mem;
   logic [DW-1:0] o_dato_mem_to_debug_unit;
   logic o_bit_sucio_to_debug_unit;

   // Reference model of memory contents and written flags.
   logic [DW-1:0] ref_mem [DEPTH];
   logic ref_dirty [DEPTH];
   logic [WW-1:0] words [NUM_TEST_WORDS];
   logic [31:0] lcg_state = 32'd21;

   mem_stage_top i_mem_stage_top (.*);

   always #(CLK_PERIOD / 2) i_clock = ~i_clock;

   ////////////////////////////////////////
   // Checking and model helpers.
   ////////////////////////////////////////

   task automatic check_value(input string what, input logic [DW-1:0] got,
                              input logic [DW-1:0] expected);
      if (got !== expected) begin
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
         $display("CHECKS FAILED");
         $fatal(1, "Stopping at the first mismatch.");
      end
   endtask

   function automatic logic [31:0] lcg();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Value a load should return from a word, by size, sign and offset.
   function automatic logic [DW-1:0] load_expect(input logic [DW-1:0] word,
                                                 input logic [2:0] sel,
                                                 input logic [1:0] lsb);
      mips_mem_pkg::mem_word_u view;
      logic [7:0] b;
      logic [15:0] h;
      view = word;
      b = view.bytes[lsb];
      h = view.halves[lsb[1]];
      case (sel)
         mips_ctrl_pkg::SEL_BYTE: return {{24{b[7]}}, b};
         mips_ctrl_pkg::SEL_BYTEU: return {24'b0, b};
         mips_ctrl_pkg::SEL_HALF: return {{16{h[15]}}, h};
         mips_ctrl_pkg::SEL_HALFU: return {16'b0, h};
         default: return word;
      endcase
   endfunction

   // Store rules. Misaligned halfwords and words change nothing.
   task automatic apply_store(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                              input logic [2:0] sel);
      mips_mem_pkg::mem_word_u view;
      logic [WW-1:0] w;
      logic [1:0] lsb;
      w = addr[AW-1:2];
      lsb = addr[1:0];
      view = ref_mem[w];
      case (sel[1:0])
         mips_ctrl_pkg::SIZE_BYTE: begin
            view.bytes[lsb] = data[7:0];
            ref_dirty[w] = 1'b1;
         end
         mips_ctrl_pkg::SIZE_HALF: begin
            if (!lsb[0]) begin
               view.halves[lsb[1]] = data[15:0];
               ref_dirty[w] = 1'b1;
            end
         end
         mips_ctrl_pkg::SIZE_WORD: begin
            if (lsb == 2'b00) begin
               view = data;
               ref_dirty[w] = 1'b1;
            end
         end
         default: ;
      endcase
      ref_mem[w] = view;
   endtask

   ////////////////////////////////////////
   // Bus-level access tasks.
   ////////////////////////////////////////

   // One enabled cycle with random write-back controls that are checked one cycle later.
   task automatic access(input logic dbg, input logic wr, input logic rd,
                         input logic [DW-1:0] alu_addr, input logic [AW-1:0] dbg_addr,
                         input logic [DW-1:0] data, input logic [2:0] sel);
      logic [DW-1:0] ctrl;
      ctrl = lcg();
      i_enable_pipeline = 1'b1;
      i_enable_mem = 1'b1;
      i_control_address_mem = dbg;
      i_address_alu = alu_addr;
      i_address_debug = dbg_addr;
      i_data_write_mem = data;
      i_mem_write = wr;
      i_mem_read = rd;
      i_select_bytes = sel;
      i_reg_write = ctrl[0];
      i_mem_to_reg = ctrl[1];
      i_halt_detected = ctrl[2];
      i_registro_destino = ctrl[7:3];
      @(negedge i_clock);
      check_value("o_data_alu", o_data_alu, alu_addr);
      check_value("write-back controls",
                  {o_reg_write, o_mem_to_reg, o_halt_detected, o_registro_destino},
                  {ctrl[0], ctrl[1], ctrl[2], ctrl[7:3]});
      if (wr && !dbg) begin
         apply_store(alu_addr[AW-1:0], data, sel);
      end
   endtask

   task automatic store(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                        input logic [2:0] sel);
      logic [DW-1:0] hi;
      hi = lcg();
      access(1'b0, 1'b1, 1'b0, {hi[DW-1:AW], addr}, '0, data, sel);
   endtask

   task automatic load(input logic [AW-1:0] addr, input logic [2:0] sel);
      logic [DW-1:0] hi;
      hi = lcg();
      access(1'b0, 1'b0, 1'b1, {hi[DW-1:AW], addr}, '0, '0, sel);
      check_value("o_data_mem", o_data_mem, load_expect(ref_mem[addr[AW-1:2]], sel, addr[1:0]));
   endtask

   // A debug read that also requests a store, which must not write.
   task automatic debug_read(input logic [WW-1:0] word);
      access(1'b1, 1'b1, 1'b0, lcg(), {word, 2'b00}, lcg(), mips_ctrl_pkg::SEL_WORD);
      check_value("dirty bit", o_bit_sucio_to_debug_unit, ref_dirty[word]);
      if (ref_dirty[word]) begin
         check_value("debug word", o_dato_mem_to_debug_unit, ref_mem[word]);
      end
   endtask

   // Every load code at every offset that it can use.
   task automatic check_loads(input logic [WW-1:0] word);
      for (int off = 0; off < 4; off++) begin
         load({word, 2'(off)}, mips_ctrl_pkg::SEL_BYTE);
         load({word, 2'(off)}, mips_ctrl_pkg::SEL_BYTEU);
      end
      for (int off = 0; off < 4; off += 2) begin
         load({word, 2'(off)}, mips_ctrl_pkg::SEL_HALF);
         load({word, 2'(off)}, mips_ctrl_pkg::SEL_HALFU);
      end
      load({word, 2'b00}, mips_ctrl_pkg::SEL_WORD);
   endtask

   ////////////////////////////////////////
   // Directed tests.
   ////////////////////////////////////////

   task automatic reset_and_scan();
      for (int w = 0; w < DEPTH; w++) begin
         ref_dirty[w] = 1'b0;
      end
      i_soft_reset = 1'b0;
      repeat (RESET_CYCLES) @(negedge i_clock);
      check_value("o_data_alu after reset", o_data_alu, '0);
      check_value("o_data_mem after reset", o_data_mem, '0);
      check_value("debug word after reset", o_dato_mem_to_debug_unit, '0);
      check_value("controls after reset",
                  {o_reg_write, o_mem_to_reg, o_halt_detected, o_registro_destino,
                   o_bit_sucio_to_debug_unit}, '0);
      i_soft_reset = 1'b1;
      for (int w = 0; w < DEPTH; w++) begin
         debug_read(WW'(w));
      end
   endtask

   task automatic word_store_load();
      logic [DW-1:0] r;
      for (int i = 0; i < NUM_TEST_WORDS; i++) begin
         r = lcg();
         words[i] = r[WW+3:4];
         store({words[i], 2'b00}, lcg(), mips_ctrl_pkg::SEL_WORD);
      end
      for (int i = 0; i < NUM_TEST_WORDS; i++) begin
         load({words[i], 2'b00}, mips_ctrl_pkg::SEL_WORD);
      end
   endtask

   task automatic narrow_store_load();
      for (int i = 0; i < 4; i++) begin
         for (int off = 0; off < 4; off++) begin
            store({words[i], 2'(off)}, lcg(), mips_ctrl_pkg::SEL_BYTE);
            check_loads(words[i]);
         end
         for (int off = 0; off < 4; off += 2) begin
            store({words[i], 2'(off)}, lcg(), mips_ctrl_pkg::SEL_HALF);
            check_loads(words[i]);
         end
      end
   endtask

   // One written word and one never-written word.
   task automatic misaligned_store();
      logic [WW-1:0] targets [2];
      targets[0] = words[4];
      targets[1] = '0;
      for (int w = DEPTH - 1; w >= 0; w--) begin
         if (!ref_dirty[w]) begin
            targets[1] = WW'(w);
         end
      end
      foreach (targets[t]) begin
         store({targets[t], 2'b01}, lcg(), mips_ctrl_pkg::SEL_HALF);
         store({targets[t], 2'b11}, lcg(), mips_ctrl_pkg::SEL_HALF);
         store({targets[t], 2'b01}, lcg(), mips_ctrl_pkg::SEL_WORD);
         store({targets[t], 2'b10}, lcg(), mips_ctrl_pkg::SEL_WORD);
         store({targets[t], 2'b11}, lcg(), mips_ctrl_pkg::SEL_WORD);
         debug_read(targets[t]);
      end
   endtask

   task automatic debug_scan();
      for (int w = 0; w < DEPTH; w++) begin
         debug_read(WW'(w));
      end
   endtask

   task automatic pipeline_stall();
      logic [DW-1:0] held_alu;
      logic [DW-1:0] held_mem;
      logic [DW-1:0] held_dbg;
      logic [DW-1:0] held_ctrl;
      debug_read(words[0]);
      held_alu = o_data_alu;
      held_mem = o_data_mem;
      held_dbg = o_dato_mem_to_debug_unit;
      held_ctrl = {o_reg_write, o_mem_to_reg, o_halt_detected, o_registro_destino,
                   o_bit_sucio_to_debug_unit};
      // An upper halfword store to another word that must not land while stalled.
      i_enable_pipeline = 1'b0;
      i_control_address_mem = 1'b0;
      i_mem_write = 1'b1;
      i_address_alu = {{(DW-AW){1'b0}}, words[1], 2'b10};
      i_data_write_mem = ~{2{ref_mem[words[1]][31:16]}};
      i_select_bytes = mips_ctrl_pkg::SEL_HALFU;
      i_reg_write = ~o_reg_write;
      i_mem_to_reg = ~o_mem_to_reg;
      i_registro_destino = ~o_registro_destino;
      i_halt_detected = ~o_halt_detected;
      repeat (3) begin
         @(negedge i_clock);
         check_value("stalled o_data_alu", o_data_alu, held_alu);
         check_value("stalled o_data_mem", o_data_mem, held_mem);
         check_value("stalled debug word", o_dato_mem_to_debug_unit, held_dbg);
         check_value("stalled controls",
                     {o_reg_write, o_mem_to_reg, o_halt_detected, o_registro_destino,
                      o_bit_sucio_to_debug_unit}, held_ctrl);
      end
      debug_read(words[1]);
      store({words[1], 2'b00}, lcg(), mips_ctrl_pkg::SEL_WORD);
      check_loads(words[1]);
   endtask

   ////////////////////////////////////////
   // Main sequence and watchdog.
   ////////////////////////////////////////

   initial begin
      i_soft_reset = 1'b0;
      i_enable_pipeline = 1'b1;
      i_enable_mem = 1'b0;
      i_control_address_mem = 1'b0;
      i_address_alu = '0;
      i_address_debug = '0;
      i_data_write_mem = '0;
      i_mem_read = 1'b0;
      i_mem_write = 1'b0;
      i_select_bytes = '0;
      i_reg_write = 1'b0;
      i_mem_to_reg = 1'b0;
      i_registro_destino = '0;
      i_halt_detected = 1'b0;
      reset_and_scan();
      word_store_load();
      narrow_store_load();
      misaligned_store();
      debug_scan();
      pipeline_stall();
      if (i_mem_stage_top.u_mem_stage_props.fail_count != 0) begin
         $display("%0d assertion failures were reported.",
                  i_mem_stage_top.u_mem_stage_props.fail_count);
         $display("CHECKS FAILED");
         $fatal(1, "Bound assertions failed.");
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

   initial begin
      #(BUDGET * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles.", BUDGET);
      $display("CHECKS FAILED");
      $fatal(1, "Watchdog expired.");
   end

endmodule

`default_nettype wire
